// ==== branch_predictor.sv ====
module branch_predictor (
    input  logic                  clk,
    input  logic                  rst,

    // From fetch
    input  lc3b_types::lc3b_word  mem_address,
    input  logic                  br_instruction,

    // Training pulses from the resolver
    input  lc3b_types::br_train_t train,

    output logic                  prediction,
    output logic                  branch_in_flight
);

    lc3b_types::lc3b_word addr_reg;
    lc3b_types::bp_index  index;

    logic [lc3b_types::PRED_ENTRIES-1:0] entry_sel;
    logic [lc3b_types::PRED_ENTRIES-1:0] entry_taken;
    logic [lc3b_types::PRED_ENTRIES-1:0] entry_not_taken;
    logic [lc3b_types::PRED_ENTRIES-1:0] entry_pred;

    logic strobe_accept;
    logic train_any;

    // Only one branch may be tracked at a time
    assign strobe_accept = br_instruction & ~branch_in_flight;
    assign train_any     = train.taken | train.not_taken;

    // Address of the branch in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_reg <= '0;
        end else if (strobe_accept) begin
            addr_reg <= mem_address;
        end
    end

    // Word address bits select the table entry
    assign index = addr_reg[lc3b_types::PRED_INDEX_LSB +: lc3b_types::PRED_INDEX_BITS];

    always_comb begin
        entry_sel        = '0;
        entry_sel[index] = 1'b1;
    end

    // Training reaches only the selected entry
    assign entry_taken     = entry_sel & {lc3b_types::PRED_ENTRIES{train.taken}};
    assign entry_not_taken = entry_sel & {lc3b_types::PRED_ENTRIES{train.not_taken}};

    // Predictor table
    genvar i;
    generate
        for (i = 0; i < lc3b_types::PRED_ENTRIES; i++) begin : g_table
            saturating_counter u_counter (
                .clk        (clk),
                .rst        (rst),
                .taken      (entry_taken[i]),
                .not_taken  (entry_not_taken[i]),
                .prediction (entry_pred[i])
            );
        end
    endgenerate

    // Follows the table, so a trained entry shows its new state next cycle
    assign prediction = entry_pred[index];

    // Resolution has priority over a new strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            branch_in_flight <= 1'b0;
        end else if (train_any) begin
            branch_in_flight <= 1'b0;
        end else if (strobe_accept) begin
            branch_in_flight <= 1'b1;
        end
    end

endmodule

// ==== branch_resolver.sv ====
module branch_resolver (
    input  logic                    clk,
    input  logic                    rst,

    // Resolution from execute
    input  lc3b_types::br_resolve_t resolve,

    // State of the branch in flight, from the predictor
    input  logic                    prediction,
    input  logic                    branch_in_flight,

    output lc3b_types::br_train_t   train,
    output logic                    mispredict,
    output lc3b_types::bp_stats_t   stats
);

    logic resolve_accept;
    logic outcome;
    logic mismatch;

    // A resolve with nothing in flight is ignored
    assign resolve_accept = resolve.valid & branch_in_flight;

    // Taken when any requested condition code is set
    assign outcome = |(resolve.nzp & resolve.cc);

    assign mismatch = outcome ^ prediction;

    // Same-cycle training pulses, one-hot while accepted
    always_comb begin
        train.taken     = resolve_accept & outcome;
        train.not_taken = resolve_accept & ~outcome;
    end

    // Registered flush request, high for one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mispredict <= 1'b0;
        end else begin
            mispredict <= resolve_accept & mismatch;
        end
    end

    // Running totals
    always_ff @(posedge clk) begin
        if (rst) begin
            stats.branches    <= '0;
            stats.mispredicts <= '0;
        end else if (resolve_accept) begin
            stats.branches <= stats.branches + 16'd1;
            if (mismatch) begin
                stats.mispredicts <= stats.mispredicts + 16'd1;
            end
        end
    end

endmodule

// ==== branch_unit.sv ====
module branch_unit (
    input  logic                    clk,
    input  logic                    rst,

    // Fetch side
    input  lc3b_types::lc3b_word    mem_address,
    input  logic                    br_instruction,

    // Execute side
    input  lc3b_types::br_resolve_t resolve,

    output logic                    prediction,
    output logic                    branch_in_flight,
    output logic                    mispredict,
    output lc3b_types::bp_stats_t   stats
);

    // Resolver back to predictor
    lc3b_types::br_train_t train;

    branch_predictor u_predictor (
        .clk              (clk),
        .rst              (rst),
        .mem_address      (mem_address),
        .br_instruction   (br_instruction),
        .train            (train),
        .prediction       (prediction),
        .branch_in_flight (branch_in_flight)
    );

    branch_resolver u_resolver (
        .clk              (clk),
        .rst              (rst),
        .resolve          (resolve),
        .prediction       (prediction),
        .branch_in_flight (branch_in_flight),
        .train            (train),
        .mispredict       (mispredict),
        .stats            (stats)
    );

endmodule

// ==== branch_unit_props.sv ====
module branch_unit_props (
    input logic                  clk,
    input logic                  rst,
    input lc3b_types::br_train_t train,
    input logic                  mispredict,
    input logic                  branch_in_flight
);

    // Training pulses are one-hot or idle
    train_one_hot: assert property (
        @(posedge clk) disable iff (rst) !(train.taken && train.not_taken)
    ) else $error("train.taken and train.not_taken are high together");

    // Flush request lasts a single cycle
    mispredict_pulse: assert property (
        @(posedge clk) disable iff (rst) mispredict |=> !mispredict
    ) else $error("mispredict stayed high for two cycles");

    reset_clears_flight: assert property (
        @(posedge clk) rst |=> !branch_in_flight
    ) else $error("branch_in_flight set in the cycle after reset");

endmodule

bind branch_unit branch_unit_props u_props (
    .clk              (clk),
    .rst              (rst),
    .train            (train),
    .mispredict       (mispredict),
    .branch_in_flight (branch_in_flight)
);

// ==== lc3b_types.sv ====
package lc3b_types;

    // Memory address as seen by fetch
    typedef logic [15:0] lc3b_word;

    // Branch nzp field and the condition codes share one layout
    typedef logic [2:0] lc3b_nzp;

    // Statistics counts, left to wrap
    typedef logic [15:0] bp_count;

    // Predictor table geometry
    localparam int PRED_INDEX_BITS = 4;
    localparam int PRED_INDEX_LSB  = 1;
    localparam int PRED_ENTRIES    = 1 << PRED_INDEX_BITS;

    typedef logic [PRED_INDEX_BITS-1:0] bp_index;

    // Two-bit saturating counter states, ordered from not taken to taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } sat_state_e;

    // One branch resolution from execute
    typedef struct packed {
        logic    valid;
        lc3b_nzp nzp;
        lc3b_nzp cc;
    } br_resolve_t;

    // Training pulses, at most one high per cycle
    typedef struct packed {
        logic taken;
        logic not_taken;
    } br_train_t;

    typedef struct packed {
        bp_count branches;
        bp_count mispredicts;
    } bp_stats_t;

endpackage

// ==== list.f ====
lc3b_types.sv
saturating_counter.sv
branch_predictor.sv
branch_resolver.sv
branch_unit.sv
branch_unit_props.sv
tb_branch_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the branch unit testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_branch_unit -f list.f \
    -o sim_branch_unit > sim.log 2>&1 \
    && ./obj_dir/sim_branch_unit >> sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== saturating_counter.sv ====
module saturating_counter (
    input  logic clk,
    input  logic rst,

    // Training strobes for this entry only
    input  logic taken,
    input  logic not_taken,

    output logic prediction
);

    lc3b_types::sat_state_e state;
    lc3b_types::sat_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lc3b_types::weak_not_taken;
        end else begin
            state <= state_next;
        end
    end

    // One step per training pulse, pinned at either end
    always_comb begin
        state_next = state;
        if (taken) begin
            unique case (state)
                lc3b_types::strong_not_taken: state_next = lc3b_types::weak_not_taken;
                lc3b_types::weak_not_taken:   state_next = lc3b_types::weak_taken;
                lc3b_types::weak_taken:       state_next = lc3b_types::strong_taken;
                lc3b_types::strong_taken:     state_next = lc3b_types::strong_taken;
                default:                      state_next = lc3b_types::weak_not_taken;
            endcase
        end else if (not_taken) begin
            unique case (state)
                lc3b_types::strong_not_taken: state_next = lc3b_types::strong_not_taken;
                lc3b_types::weak_not_taken:   state_next = lc3b_types::strong_not_taken;
                lc3b_types::weak_taken:       state_next = lc3b_types::weak_not_taken;
                lc3b_types::strong_taken:     state_next = lc3b_types::weak_taken;
                default:                      state_next = lc3b_types::weak_not_taken;
            endcase
        end
    end

    // Taken side of the table
    always_comb begin
        prediction = (state == lc3b_types::weak_taken) ||
                     (state == lc3b_types::strong_taken);
    end

endmodule

// ==== tb_branch_unit.sv ====
module tb_branch_unit;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 8;
    localparam int RANDOM_ROUNDS = 200;
    localparam int TEST_CYCLES   = RESET_CYCLES + 32 + 10 + 12 + 10 + RANDOM_ROUNDS * 2 + 6;
    localparam int WATCHDOG_TIME = (TEST_CYCLES + 200) * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst;
    lc3b_types::lc3b_word    mem_address;
    logic                    br_instruction;
    lc3b_types::br_resolve_t resolve;
    logic                    prediction;
    logic                    branch_in_flight;
    logic                    mispredict;
    lc3b_types::bp_stats_t   stats;

    // Reference model state
    logic [1:0]          model_ctr [lc3b_types::PRED_ENTRIES];
    lc3b_types::bp_index model_index;
    logic                model_in_flight;
    logic                model_mispredict;
    lc3b_types::bp_count model_branches;
    lc3b_types::bp_count model_mispredicts;

    logic [15:0] lfsr;
    string       current_test;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    branch_unit UUT (
        .clk              (clk),
        .rst              (rst),
        .mem_address      (mem_address),
        .br_instruction   (br_instruction),
        .resolve          (resolve),
        .prediction       (prediction),
        .branch_in_flight (branch_in_flight),
        .mispredict       (mispredict),
        .stats            (stats)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic feedback;
        feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output logic [15:0] value);
        value = '0;
        for (int k = 0; k < count; k++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[14:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %0h, actual %0h", current_test, what,
                     expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_model();
        check_value("prediction", 16'(model_ctr[model_index][1]), 16'(prediction));
        check_value("branch_in_flight", 16'(model_in_flight), 16'(branch_in_flight));
        check_value("mispredict", 16'(model_mispredict), 16'(mispredict));
        check_value("branches", model_branches, stats.branches);
        check_value("mispredicts", model_mispredicts, stats.mispredicts);
    endtask

    // One clock of stimulus, with the model stepped by the same rules
    task automatic run_cycle(input logic strobe_en, input lc3b_types::lc3b_word addr,
                             input logic valid, input lc3b_types::lc3b_nzp nzp,
                             input lc3b_types::lc3b_nzp cc);
        logic outcome;
        logic predicted;
        br_instruction = strobe_en;
        mem_address    = addr;
        resolve.valid  = valid;
        resolve.nzp    = nzp;
        resolve.cc     = cc;
        outcome = 1'b0;
        for (int k = 0; k < 3; k++) begin
            if (nzp[k] && cc[k]) begin
                outcome = 1'b1;
            end
        end
        predicted        = model_ctr[model_index][1];
        model_mispredict = 1'b0;
        if (valid && model_in_flight) begin
            model_in_flight  = 1'b0;
            model_mispredict = (outcome != predicted);
            model_branches   = model_branches + 16'd1;
            if (outcome != predicted) begin
                model_mispredicts = model_mispredicts + 16'd1;
            end
            if (outcome && model_ctr[model_index] != 2'd3) begin
                model_ctr[model_index] = model_ctr[model_index] + 2'd1;
            end else if (!outcome && model_ctr[model_index] != 2'd0) begin
                model_ctr[model_index] = model_ctr[model_index] - 2'd1;
            end
        end else if (strobe_en && !model_in_flight) begin
            model_index     = addr[4:1];
            model_in_flight = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        br_instruction = 1'b0;
        resolve        = '0;
    endtask

    task automatic fetch_branch(input lc3b_types::lc3b_word addr);
        run_cycle(1'b1, addr, 1'b0, 3'b000, 3'b000);
    endtask

    task automatic resolve_branch(input logic taken);
        if (taken) begin
            run_cycle(1'b0, 16'h0000, 1'b1, 3'b111, 3'b010);
        end else begin
            run_cycle(1'b0, 16'h0000, 1'b1, 3'b001, 3'b100);
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: passed", current_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", current_test, test_errors);
        end
    endtask

    initial begin
        #WATCHDOG_TIME;
        $display("Watchdog expired before the tests completed");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [15:0] r_addr;
        logic [15:0] r_nzp;
        logic [15:0] r_cc;
        lc3b_types::bp_count saved_branches;
        rst            = 1'b1;
        mem_address    = '0;
        br_instruction = 1'b0;
        resolve        = '0;
        lfsr           = 16'd98;
        total_errors   = 0;
        tests_run      = 0;
        tests_failed   = 0;
        for (int i = 0; i < lc3b_types::PRED_ENTRIES; i++) begin
            model_ctr[i] = 2'd1;
        end
        model_index       = '0;
        model_in_flight   = 1'b0;
        model_mispredict  = 1'b0;
        model_branches    = '0;
        model_mispredicts = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        start_test("reset_state");
        for (int i = 0; i < lc3b_types::PRED_ENTRIES; i++) begin
            fetch_branch(16'(i << 1));
            check_value("prediction", 16'd0, 16'(prediction));
            check_value("branch_in_flight", 16'd1, 16'(branch_in_flight));
            resolve_branch(1'b0);
            check_model();
        end
        check_value("branches", 16'd16, stats.branches);
        check_value("mispredicts", 16'd0, stats.mispredicts);
        end_test();

        start_test("saturation");
        for (int k = 0; k < 5; k++) begin
            fetch_branch(16'h000A);
            resolve_branch(k < 4);
            check_value("prediction after resolve", (k == 0) ? 16'd0 : 16'd1,
                        16'(prediction));
            check_model();
        end
        end_test();

        start_test("aliasing");
        fetch_branch(16'h0016);
        resolve_branch(1'b1);
        fetch_branch(16'h0016);
        resolve_branch(1'b1);
        // Same bits 4:1, other upper bits and bit 0
        fetch_branch(16'h8017);
        check_value("shared entry", 16'd1, 16'(prediction));
        check_model();
        resolve_branch(1'b0);
        // Entry 5 still predicts taken while the shared entry has dropped
        fetch_branch(16'h000A);
        check_value("separate entry", 16'd1, 16'(prediction));
        check_model();
        resolve_branch(1'b1);
        check_model();
        end_test();

        start_test("in_flight_gating");
        fetch_branch(16'h0016);
        fetch_branch(16'h000A);
        check_value("prediction kept", 16'd0, 16'(prediction));
        check_model();
        resolve_branch(1'b1);
        check_value("prediction trained", 16'd1, 16'(prediction));
        saved_branches = model_branches;
        resolve_branch(1'b0);
        check_value("stray resolve prediction", 16'd1, 16'(prediction));
        check_value("stray resolve branches", saved_branches, stats.branches);
        check_model();
        end_test();

        start_test("random_mispredict");
        for (int n = 0; n < RANDOM_ROUNDS; n++) begin
            draw_bits(16, r_addr);
            draw_bits(3, r_nzp);
            draw_bits(3, r_cc);
            fetch_branch(r_addr);
            check_model();
            run_cycle(1'b0, 16'h0000, 1'b1, r_nzp[2:0], r_cc[2:0]);
            check_model();
        end
        end_test();

        start_test("strobe_with_resolve");
        fetch_branch(16'h0002);
        run_cycle(1'b1, 16'h001E, 1'b1, 3'b111, 3'b010);
        check_value("branch_in_flight", 16'd0, 16'(branch_in_flight));
        check_model();
        run_cycle(1'b0, 16'h0000, 1'b0, 3'b000, 3'b000);
        check_value("dropped strobe", 16'd0, 16'(branch_in_flight));
        check_model();
        end_test();

        $display("Summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
